// ==== hw/cnn_mem_pkg.sv ====
`default_nettype none

// ====================
// Memory bus types
// ====================
package cnn_mem_pkg;

  localparam int unsigned ADDR_W   = 19;
  localparam int unsigned RD_BYTES = 16;  // Widest read beat
  localparam int unsigned WR_BYTES = 4;   // One packed result word

  typedef logic [ADDR_W-1:0]         mem_addr_t;   // Byte address
  typedef logic [RD_BYTES*8-1:0]     rd_data_t;    // Byte 0 in bits 7:0
  typedef logic [WR_BYTES*8-1:0]     wr_data_t;
  typedef logic [$clog2(RD_BYTES):0] rd_size_t;    // 1 to RD_BYTES
  typedef logic [$clog2(WR_BYTES):0] wr_size_t;    // 1 to WR_BYTES

  typedef struct packed {
    logic      req;
    mem_addr_t addr;
    rd_size_t  size;
  } mem_rd_req_t;

  typedef struct packed {
    logic     valid;   // Data is good in this cycle only
    rd_data_t data;
  } mem_rd_rsp_t;

  typedef struct packed {
    logic      req;
    mem_addr_t addr;
    wr_data_t  data;
    wr_size_t  size;
  } mem_wr_req_t;

endpackage

`default_nettype wire

// ==== hw/cnn_arith_pkg.sv ====
`default_nettype none

// ====================
// Datapath and control types
// ====================
package cnn_arith_pkg;

  localparam int unsigned KERNEL_DIM = 4;  // Kernel is KERNEL_DIM x KERNEL_DIM

  typedef logic        [7:0]  pixel_t;     // Unsigned picture sample
  typedef logic signed [7:0]  weight_t;
  typedef logic signed [31:0] acc_t;       // Also the bias format
  typedef logic        [7:0]  result_t;    // After clamping

  // Addresses written by software before go
  typedef struct packed {
    cnn_mem_pkg::mem_addr_t addr_pic;
    cnn_mem_pkg::mem_addr_t addr_wgt;
    cnn_mem_pkg::mem_addr_t addr_bias;
    cnn_mem_pkg::mem_addr_t addr_out;
  } cnn_cfg_t;

  typedef enum logic [2:0] {
    IDLE       = 3'd0,
    LOAD_WGT   = 3'd1,  // Kernel read, once per run
    LOAD_BIAS  = 3'd2,
    READ_ROW   = 3'd3,  // One picture row of the window
    FINISH_WIN = 3'd4,  // Wait for the packer before the next window
    DRAIN      = 3'd5
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== hw/cnn_cfg_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_cfg_regs (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    go,
  input  cnn_arith_pkg::cnn_cfg_t cfg,
  input  logic                    all_written,
  output cnn_arith_pkg::cnn_cfg_t cfg_q,
  output logic                    start,
  output logic                    busy,
  output logic                    done
);

  import cnn_arith_pkg::*;

  logic go_ok;

  assign go_ok = go && !busy;  // A go during a run is dropped

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      busy  <= 1'b0;
      start <= 1'b0;
    end
    else
    begin
      start <= go_ok;
      if (go_ok)
        busy <= 1'b1;
      else if (all_written)
        busy <= 1'b0;  // Low from the cycle after done
    end
  end

  // Addresses held for the whole run
  always_ff @(posedge clk)
  begin
    if (go_ok)
      cfg_q <= cfg;
  end

  assign done = busy && all_written;

  // The packer only reports completion while a run is in flight
  a_written_busy: assert property (@(posedge clk) disable iff (!rst_n)
    all_written |-> busy)
    else $error("all_written arrived outside a run");

endmodule

`default_nettype wire

// ==== hw/cnn_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_ctrl #(
  parameter int unsigned PIC_ROWS = 16,
  parameter int unsigned PIC_COLS = 16
) (
  input  logic                       clk,
  input  logic                       rst_n,
  input  logic                       start,
  input  cnn_arith_pkg::cnn_cfg_t    cfg_q,
  output cnn_mem_pkg::mem_rd_req_t   rd_req,
  input  cnn_mem_pkg::mem_rd_rsp_t   rd_rsp,
  input  logic                       pack_busy,
  output logic                       row_vld,
  output logic                       last,
  output logic                       mac_start,
  output logic                       bias_vld,
  output cnn_arith_pkg::pixel_t      pix [cnn_arith_pkg::KERNEL_DIM],
  output cnn_arith_pkg::weight_t     wgt [cnn_arith_pkg::KERNEL_DIM],
  output cnn_arith_pkg::acc_t        bias
);

  import cnn_mem_pkg::*;
  import cnn_arith_pkg::*;

  localparam int unsigned ROW_W    = $clog2(PIC_ROWS);
  localparam int unsigned COL_W    = $clog2(PIC_COLS);
  localparam int unsigned KR_W     = $clog2(KERNEL_DIM);
  localparam int unsigned LAST_ROW = PIC_ROWS - KERNEL_DIM;  // Top row of the last window
  localparam int unsigned LAST_COL = PIC_COLS - KERNEL_DIM;

  ctrl_state_t      state;
  logic [ROW_W-1:0] wr_row;     // Window top row
  logic [ROW_W-1:0] pic_row;
  logic [COL_W-1:0] wc;         // Window left column
  logic [KR_W-1:0]  kr;         // Row inside the window
  logic [1:0]       fin_cnt;    // Covers the MAC latency
  logic             rd_done;
  logic             last_win;
  logic             pack_free;
  rd_data_t         wgt_q;
  mem_addr_t        pic_addr;

  assign rd_done   = rd_req.req && rd_rsp.valid;
  assign pic_row   = wr_row + ROW_W'(kr);
  assign pic_addr  = cfg_q.addr_pic + mem_addr_t'(pic_row) * mem_addr_t'(PIC_COLS)
                   + mem_addr_t'(wc);
  assign last_win  = (wr_row == ROW_W'(LAST_ROW)) && (wc == COL_W'(LAST_COL));
  assign pack_free = (fin_cnt == 2'd3) && !pack_busy;

  // ====================
  // FSM and read requests
  // ====================
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state     <= IDLE;
      rd_req    <= '0;
      wr_row    <= '0;
      wc        <= '0;
      kr        <= '0;
      fin_cnt   <= '0;
      row_vld   <= 1'b0;
      last      <= 1'b0;
      mac_start <= 1'b0;
      bias_vld  <= 1'b0;
    end
    else
    begin
      row_vld   <= 1'b0;
      mac_start <= 1'b0;
      bias_vld  <= 1'b0;
      if (rd_done)
        rd_req.req <= 1'b0;  // Request ends with its data beat

      if (state == FINISH_WIN || state == DRAIN)
      begin
        if (fin_cnt != 2'd3)
          fin_cnt <= fin_cnt + 2'd1;
      end
      else
        fin_cnt <= '0;

      case (state)
        IDLE:
        begin
          if (start)
          begin
            mac_start <= 1'b1;
            wr_row    <= '0;
            wc        <= '0;
            kr        <= '0;
            rd_req    <= '{req: 1'b1, addr: cfg_q.addr_wgt, size: rd_size_t'(RD_BYTES)};
            state     <= LOAD_WGT;
          end
        end
        LOAD_WGT:
        begin
          if (rd_done)
            state <= LOAD_BIAS;
        end
        LOAD_BIAS:
        begin
          if (!rd_req.req)
            rd_req <= '{req: 1'b1, addr: cfg_q.addr_bias, size: rd_size_t'(4)};
          else if (rd_done)
          begin
            bias_vld <= 1'b1;
            state    <= READ_ROW;
          end
        end
        READ_ROW:
        begin
          if (!rd_req.req)
            rd_req <= '{req: 1'b1, addr: pic_addr, size: rd_size_t'(KERNEL_DIM)};
          else if (rd_done)
          begin
            row_vld <= 1'b1;
            last    <= (kr == KR_W'(KERNEL_DIM - 1));
            kr      <= kr + 1'b1;  // Wraps to 0 after the last row
            if (kr == KR_W'(KERNEL_DIM - 1))
              state <= FINISH_WIN;
          end
        end
        FINISH_WIN:
        begin
          if (last_win)
            state <= DRAIN;
          else if (pack_free)
          begin
            if (wc == COL_W'(LAST_COL))
            begin
              wc     <= '0;
              wr_row <= wr_row + 1'b1;
            end
            else
              wc <= wc + 1'b1;
            state <= READ_ROW;
          end
        end
        DRAIN:
        begin
          if (pack_free)
            state <= IDLE;  // Last word is acked
        end
        default:
          state <= IDLE;
      endcase
    end
  end

  // Kernel, bias and row operands
  always_ff @(posedge clk)
  begin
    if (state == LOAD_WGT && rd_done)
      wgt_q <= rd_rsp.data;
    if (state == LOAD_BIAS && rd_done)
      bias <= acc_t'(rd_rsp.data[31:0]);
    if (state == READ_ROW && rd_done)
    begin
      for (int k = 0; k < KERNEL_DIM; k++)
      begin
        pix[k] <= pixel_t'(rd_rsp.data[k*8 +: 8]);
        wgt[k] <= weight_t'(wgt_q[(int'(kr)*KERNEL_DIM + k)*8 +: 8]);
      end
    end
  end

  // Outstanding read is neither replaced nor dropped before its data
  a_rd_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rd_req.req && !rd_rsp.valid |=> rd_req.req && $stable(rd_req.addr)
                                    && $stable(rd_req.size))
    else $error("read request changed while outstanding");

endmodule

`default_nettype wire

// ==== hw/cnn_mac.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_mac (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    mac_start,
  input  logic                    row_vld,
  input  logic                    last,
  input  logic                    bias_vld,
  input  cnn_arith_pkg::pixel_t   pix [cnn_arith_pkg::KERNEL_DIM],
  input  cnn_arith_pkg::weight_t  wgt [cnn_arith_pkg::KERNEL_DIM],
  input  cnn_arith_pkg::acc_t     bias,
  output logic                    res_vld,
  output cnn_arith_pkg::result_t  res
);

  import cnn_arith_pkg::*;

  acc_t    dot;        // Row dot product
  acc_t    acc;        // Window sum
  acc_t    bias_q;
  acc_t    act_sum;
  result_t act_res;
  logic    acc_first;  // Next row opens a window
  logic    fin;        // acc holds a complete window

  // Pixels are unsigned, so they get a zero sign bit
  always_comb
  begin
    dot = '0;
    for (int k = 0; k < KERNEL_DIM; k++)
      dot = dot + acc_t'($signed({1'b0, pix[k]})) * acc_t'(wgt[k]);
  end

  // Stage 1 accumulate
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      acc_first <= 1'b1;
      fin       <= 1'b0;
    end
    else if (mac_start)
    begin
      acc_first <= 1'b1;
      fin       <= 1'b0;
    end
    else
    begin
      fin <= row_vld && last;
      if (row_vld)
        acc_first <= last;
    end
  end

  always_ff @(posedge clk)
  begin
    if (row_vld)
      acc <= (acc_first ? acc_t'(0) : acc) + dot;
    if (bias_vld)
      bias_q <= bias;
  end

  // ====================
  // Bias and activation
  // ====================
  always_comb
  begin
    act_sum = acc + bias_q;
    if (act_sum < 0)
      act_res = '0;
    else if (act_sum > acc_t'(255))
      act_res = 8'hff;  // Saturate high
    else
      act_res = result_t'(act_sum[7:0]);
  end

  // Stage 2 reads acc while the next window may already refill it
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
      res_vld <= 1'b0;
    else
      res_vld <= fin;
  end

  always_ff @(posedge clk)
  begin
    if (fin)
      res <= act_res;
  end

endmodule

`default_nettype wire

// ==== hw/cnn_out_pack.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_out_pack #(
  parameter int unsigned PIC_ROWS = 16,
  parameter int unsigned PIC_COLS = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      mac_start,
  input  cnn_mem_pkg::mem_addr_t    addr_out,
  input  logic                      res_vld,
  input  cnn_arith_pkg::result_t    res,
  output cnn_mem_pkg::mem_wr_req_t  wr_req,
  input  logic                      wr_ack,
  output logic                      pack_busy,
  output logic                      all_written
);

  import cnn_mem_pkg::*;
  import cnn_arith_pkg::*;

  // Results in one run
  localparam int unsigned N_RES = (PIC_ROWS - KERNEL_DIM + 1) * (PIC_COLS - KERNEL_DIM + 1);
  localparam int unsigned CNT_W = $clog2(N_RES + 1);

  logic [CNT_W-1:0] res_cnt;
  logic [1:0]       byte_idx;
  logic             word_done;
  logic             req_q;
  mem_addr_t        waddr_q;
  wr_data_t         word_q;
  wr_size_t         size_q;

  assign byte_idx  = res_cnt[1:0];
  assign word_done = res_vld && (byte_idx == 2'd3 || res_cnt == CNT_W'(N_RES - 1));

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      req_q       <= 1'b0;
      res_cnt     <= '0;
      waddr_q     <= '0;
      size_q      <= '0;
      all_written <= 1'b0;
    end
    else
    begin
      all_written <= 1'b0;
      if (mac_start)
      begin
        res_cnt <= '0;
        waddr_q <= addr_out;
      end
      else if (res_vld)
      begin
        res_cnt <= res_cnt + 1'b1;
        if (word_done)
        begin
          req_q  <= 1'b1;
          size_q <= wr_size_t'({1'b0, byte_idx}) + wr_size_t'(1);  // Short on a flush
        end
      end
      if (req_q && wr_ack)
      begin
        req_q   <= 1'b0;
        waddr_q <= waddr_q + mem_addr_t'(WR_BYTES);
        if (res_cnt == CNT_W'(N_RES))
          all_written <= 1'b1;
      end
    end
  end

  // Little-endian byte lanes, upper lanes zero on a partial word
  always_ff @(posedge clk)
  begin
    if (mac_start || (req_q && wr_ack))
      word_q <= '0;
    else if (res_vld)
      word_q[byte_idx*8 +: 8] <= res;
  end

  assign wr_req    = '{req: req_q, addr: waddr_q, data: word_q, size: size_q};
  assign pack_busy = req_q;

  // Also catches a result that lands while the word waits
  a_wr_hold: assert property (@(posedge clk) disable iff (!rst_n)
    wr_req.req && !wr_ack |=> wr_req.req && $stable(wr_req.addr)
                              && $stable(wr_req.data) && $stable(wr_req.size))
    else $error("write request changed before its ack");

endmodule

`default_nettype wire

// ==== hw/cnn_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_top #(
  parameter int unsigned PIC_ROWS = 16,
  parameter int unsigned PIC_COLS = 16
) (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      go,
  input  cnn_arith_pkg::cnn_cfg_t   cfg,
  output logic                      busy,
  output logic                      done,
  output cnn_mem_pkg::mem_rd_req_t  rd_req,
  input  cnn_mem_pkg::mem_rd_rsp_t  rd_rsp,
  output cnn_mem_pkg::mem_wr_req_t  wr_req,
  input  logic                      wr_ack
);

  import cnn_arith_pkg::*;

  cnn_cfg_t cfg_q;
  logic     start;
  logic     all_written;
  logic     pack_busy;
  logic     row_vld;
  logic     last;
  logic     mac_start;
  logic     bias_vld;
  pixel_t   pix [KERNEL_DIM];
  weight_t  wgt [KERNEL_DIM];
  acc_t     bias;
  logic     res_vld;
  result_t  res;

  // ====================
  // Software side
  // ====================
  cnn_cfg_regs u_cfg_regs (
    .clk         (clk),
    .rst_n       (rst_n),
    .go          (go),
    .cfg         (cfg),
    .all_written (all_written),
    .cfg_q       (cfg_q),
    .start       (start),
    .busy        (busy),
    .done        (done)
  );

  cnn_ctrl #(
    .PIC_ROWS (PIC_ROWS),
    .PIC_COLS (PIC_COLS)
  ) u_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (start),
    .cfg_q     (cfg_q),
    .rd_req    (rd_req),
    .rd_rsp    (rd_rsp),
    .pack_busy (pack_busy),
    .row_vld   (row_vld),
    .last      (last),
    .mac_start (mac_start),
    .bias_vld  (bias_vld),
    .pix       (pix),
    .wgt       (wgt),
    .bias      (bias)
  );

  cnn_mac u_mac (
    .clk       (clk),
    .rst_n     (rst_n),
    .mac_start (mac_start),
    .row_vld   (row_vld),
    .last      (last),
    .bias_vld  (bias_vld),
    .pix       (pix),
    .wgt       (wgt),
    .bias      (bias),
    .res_vld   (res_vld),
    .res       (res)
  );

  cnn_out_pack #(
    .PIC_ROWS (PIC_ROWS),
    .PIC_COLS (PIC_COLS)
  ) u_out_pack (
    .clk         (clk),
    .rst_n       (rst_n),
    .mac_start   (mac_start),
    .addr_out    (cfg_q.addr_out),
    .res_vld     (res_vld),
    .res         (res),
    .wr_req      (wr_req),
    .wr_ack      (wr_ack),
    .pack_busy   (pack_busy),
    .all_written (all_written)
  );

endmodule

`default_nettype wire

// ==== tb/cnn_mem_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module cnn_mem_model (
  input  logic                      clk,
  input  logic                      rst_n,
  input  cnn_mem_pkg::mem_rd_req_t  rd_req,
  output cnn_mem_pkg::mem_rd_rsp_t  rd_rsp,
  input  cnn_mem_pkg::mem_wr_req_t  wr_req,
  output logic                      wr_ack
);

  import cnn_mem_pkg::*;

  logic [7:0] mem [0:(1 << ADDR_W) - 1];  // Byte wide, loaded by the testbench
  mem_addr_t  wr_addr_log [0:15];         // Write log, one entry per ack
  wr_size_t   wr_size_log [0:15];
  int         wr_count = 0;
  int         wr_lat_fixed = 0;           // 0 selects a random write latency
  integer     seed = 94604;

  // ====================
  // Read port
  // ====================
  initial
  begin : rd_port
    int   wait_cnt;
    logic pending;
    rd_rsp   = '0;
    pending  = 1'b0;
    wait_cnt = 0;
    forever
    begin
      @(posedge clk);
      #2;
      rd_rsp.valid = 1'b0;  // Data beat lasts one cycle
      if (!rst_n)
        pending = 1'b0;
      else
      begin
        if (!pending && rd_req.req)
        begin
          pending  = 1'b1;
          wait_cnt = 1 + int'($unsigned($random(seed)) % 6);
        end
        if (pending)
        begin
          wait_cnt--;
          if (wait_cnt == 0)
          begin
            rd_rsp.data = '0;
            for (int i = 0; i < int'(RD_BYTES); i++)
            begin
              if (i < int'(rd_req.size))
                rd_rsp.data[i*8 +: 8] = mem[rd_req.addr + mem_addr_t'(i)];
            end
            rd_rsp.valid = 1'b1;
            pending      = 1'b0;
          end
        end
      end
    end
  end

  // ====================
  // Write port
  // ====================
  initial
  begin : wr_port
    int   wait_cnt;
    logic pending;
    wr_ack   = 1'b0;
    pending  = 1'b0;
    wait_cnt = 0;
    forever
    begin
      @(posedge clk);
      #2;
      wr_ack = 1'b0;
      if (!rst_n)
        pending = 1'b0;
      else
      begin
        if (!pending && wr_req.req)
        begin
          pending  = 1'b1;
          wait_cnt = (wr_lat_fixed > 0) ? wr_lat_fixed
                                        : 1 + int'($unsigned($random(seed)) % 5);
        end
        if (pending)
        begin
          wait_cnt--;
          if (wait_cnt == 0)
          begin
            for (int i = 0; i < int'(wr_req.size); i++)
              mem[wr_req.addr + mem_addr_t'(i)] = wr_req.data[i*8 +: 8];
            if (wr_count < 16)
            begin
              wr_addr_log[wr_count] = wr_req.addr;
              wr_size_log[wr_count] = wr_req.size;
            end
            wr_count++;
            wr_ack  = 1'b1;
            pending = 1'b0;
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb/cnn_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cnn;

  import cnn_mem_pkg::*;
  import cnn_arith_pkg::*;

  localparam int PIC_ROWS = 6;
  localparam int PIC_COLS = 7;
  localparam int WIN_ROWS = PIC_ROWS - KERNEL_DIM + 1;
  localparam int WIN_COLS = PIC_COLS - KERNEL_DIM + 1;
  localparam int N_RES    = WIN_ROWS * WIN_COLS;  // 12 results
  localparam int N_WORDS  = (N_RES + 3) / 4;
  localparam int TIMEOUT  = 4000;                 // Cycles per wait

  logic        clk;
  logic        rst_n;
  logic        go;
  cnn_cfg_t    cfg;
  logic        busy;
  logic        done;
  mem_rd_req_t rd_req;
  mem_rd_rsp_t rd_rsp;
  mem_wr_req_t wr_req;
  logic        wr_ack;

  // Reference copy of the inputs
  pixel_t  pic_img [PIC_ROWS*PIC_COLS];
  weight_t wgt_k   [KERNEL_DIM*KERNEL_DIM];
  acc_t    bias_v;

  integer   seed;
  int       mismatches;
  int       failures;
  int       done_cnt;
  logic     wr_req_prev;
  cnn_cfg_t run_cfg;  // Addresses of the run in flight

  always #20 clk = ~clk;

  cnn_top #(
    .PIC_ROWS (PIC_ROWS),
    .PIC_COLS (PIC_COLS)
  ) dut0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .go     (go),
    .cfg    (cfg),
    .busy   (busy),
    .done   (done),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .wr_req (wr_req),
    .wr_ack (wr_ack)
  );

  cnn_mem_model mem0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .rd_req (rd_req),
    .rd_rsp (rd_rsp),
    .wr_req (wr_req),
    .wr_ack (wr_ack)
  );

  task automatic note_mismatch(string sig, logic [31:0] got, logic [31:0] exp);
    $display("ERR %s got %h exp %h at %0t", sig, got, exp, $time);
    mismatches++;
  endtask

  task automatic note_failure(string msg);
    $display("Failure at %0t: %s", $time, msg);
    failures++;
  endtask

  // Kernel reads are one full beat, bias and picture rows are 4 bytes
  function automatic int read_size_for(mem_addr_t a);
    if (a == run_cfg.addr_wgt)
      return RD_BYTES;
    return 4;
  endfunction

  // Watches read sizes and the write handshake, counts done pulses
  always @(posedge clk)
  begin
    #1;
    if (rst_n)
    begin
      if (rd_req.req && rd_req.size !== read_size_for(rd_req.addr))
        note_mismatch("rd_req.size", rd_req.size, read_size_for(rd_req.addr));
      if (wr_ack && !wr_req_prev)
        note_failure("write ack arrived with no write request");
      if (wr_ack && wr_req.req)
        note_failure("write request still high after its ack, two writes outstanding");
      if (done)
      begin
        done_cnt++;
        if (!wr_ack)
          note_failure("done pulsed without a write ack in the cycle before");
      end
    end
    wr_req_prev = wr_req.req;
  end

  // ====================
  // Helpers
  // ====================
  function automatic cnn_cfg_t make_cfg(int a_pic, int a_wgt, int a_bias, int a_out);
    cnn_cfg_t c;
    c.addr_pic  = mem_addr_t'(a_pic);
    c.addr_wgt  = mem_addr_t'(a_wgt);
    c.addr_bias = mem_addr_t'(a_bias);
    c.addr_out  = mem_addr_t'(a_out);
    return c;
  endfunction

  // Window sum plus bias, clamped to 0..255
  function automatic result_t ref_result(int r, int c);
    int sum;
    sum = bias_v;
    for (int i = 0; i < KERNEL_DIM; i++)
      for (int j = 0; j < KERNEL_DIM; j++)
        sum += int'(pic_img[(r + i) * PIC_COLS + c + j]) * int'(wgt_k[i * KERNEL_DIM + j]);
    if (sum < 0)
      return 8'h00;
    if (sum > 255)
      return 8'hff;
    return result_t'(sum);
  endfunction

  task automatic randomize_inputs(logic [7:0] pix_mask);
    foreach (pic_img[i])
      pic_img[i] = pixel_t'($random(seed)) & pix_mask;
    foreach (wgt_k[i])
      wgt_k[i] = weight_t'($random(seed) % 2);  // -1, 0 or 1
    bias_v = acc_t'($random(seed) % 128);
  endtask

  task automatic load_memory(cnn_cfg_t c);
    mem_addr_t a;
    for (int i = 0; i < PIC_ROWS * PIC_COLS; i++)
      mem0.mem[c.addr_pic + mem_addr_t'(i)] = pic_img[i];
    for (int i = 0; i < KERNEL_DIM * KERNEL_DIM; i++)
      mem0.mem[c.addr_wgt + mem_addr_t'(i)] = wgt_k[i];
    for (int i = 0; i < 4; i++)
      mem0.mem[c.addr_bias + mem_addr_t'(i)] = bias_v[i*8 +: 8];  // Little-endian
    for (int i = 0; i < N_WORDS * 4; i++)
    begin
      a = c.addr_out + mem_addr_t'(i);
      mem0.mem[a] = a[7:0] ^ a[15:8] ^ {5'b0, a[18:16]} ^ 8'h5a;  // Stale output pattern
    end
  endtask

  task automatic pulse_go(cnn_cfg_t c);
    @(posedge clk);
    #2;
    cfg     = c;
    run_cfg = c;
    go      = 1'b1;
    @(posedge clk);
    #2;
    go  = 1'b0;
  endtask

  task automatic wait_run_done();
    int cyc;
    logic seen;
    cyc  = 0;
    seen = 1'b0;
    while (!seen && cyc < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      seen = done;
      cyc++;
    end
    if (!seen)
      note_failure("timed out waiting for done");
  endtask

  task automatic run_conv(cnn_cfg_t c);
    load_memory(c);
    mem0.wr_count = 0;
    pulse_go(c);
    wait_run_done();
    @(posedge clk);
    #2;
  endtask

  task automatic check_output(cnn_cfg_t c);
    int size_exp;
    if (mem0.wr_count != N_WORDS)
      note_failure($sformatf("%0d writes seen, %0d expected", mem0.wr_count, N_WORDS));
    for (int w = 0; w < N_WORDS && w < mem0.wr_count; w++)
    begin
      size_exp = (N_RES - 4 * w >= 4) ? 4 : N_RES - 4 * w;
      if (mem0.wr_addr_log[w] !== c.addr_out + mem_addr_t'(4 * w))
        note_mismatch("wr_req.addr", mem0.wr_addr_log[w], c.addr_out + mem_addr_t'(4 * w));
      if (mem0.wr_size_log[w] !== wr_size_t'(size_exp))
        note_mismatch("wr_req.size", mem0.wr_size_log[w], size_exp);
    end
    for (int n = 0; n < N_RES; n++)
    begin
      if (mem0.mem[c.addr_out + mem_addr_t'(n)] !== ref_result(n / WIN_COLS, n % WIN_COLS))
        note_mismatch($sformatf("wr_req.data byte %0d", n),
                      mem0.mem[c.addr_out + mem_addr_t'(n)],
                      ref_result(n / WIN_COLS, n % WIN_COLS));
    end
  endtask

  task automatic check_fixed(cnn_cfg_t c, result_t val);
    for (int n = 0; n < N_RES; n++)
    begin
      if (mem0.mem[c.addr_out + mem_addr_t'(n)] !== val)
        note_mismatch($sformatf("wr_req.data byte %0d", n),
                      mem0.mem[c.addr_out + mem_addr_t'(n)], val);
    end
  endtask

  // ====================
  // Directed tests
  // ====================
  task automatic test_reset_idle();
    @(posedge clk);
    #1;
    if (busy !== 1'b0)
      note_mismatch("busy", busy, 0);
    if (done !== 1'b0)
      note_mismatch("done", done, 0);
    if (rd_req.req !== 1'b0)
      note_mismatch("rd_req.req", rd_req.req, 0);
    if (wr_req.req !== 1'b0)
      note_mismatch("wr_req.req", wr_req.req, 0);
  endtask

  task automatic test_basic_conv();
    cnn_cfg_t c;
    randomize_inputs(8'h3f);
    c = make_cfg('h1000, 'h1100, 'h1200, 'h1300);
    run_conv(c);
    check_output(c);
  endtask

  task automatic test_clamp();
    cnn_cfg_t c;
    foreach (pic_img[i])
      pic_img[i] = pixel_t'($random(seed));
    foreach (wgt_k[i])
      wgt_k[i] = 8'sd127;
    bias_v = 1000;
    c = make_cfg('h2000, 'h2100, 'h2200, 'h2300);
    run_conv(c);
    check_fixed(c, 8'hff);
    foreach (wgt_k[i])
      wgt_k[i] = -8'sd128;
    bias_v = -1000;
    c = make_cfg('h2000, 'h2100, 'h2200, 'h2400);
    run_conv(c);
    check_fixed(c, 8'h00);
  endtask

  task automatic test_busy_done();
    cnn_cfg_t c;
    cnn_cfg_t c2;
    logic     seen;
    int       cyc;
    randomize_inputs(8'h3f);
    c  = make_cfg('h4000, 'h4100, 'h4200, 'h4300);
    c2 = make_cfg('h5000, 'h5100, 'h5200, 'h5300);
    load_memory(c);
    mem0.wr_count = 0;
    done_cnt = 0;
    if (busy !== 1'b0)
      note_mismatch("busy", busy, 0);
    pulse_go(c);
    seen = 1'b0;
    cyc  = 0;
    while (!seen && cyc < TIMEOUT)
    begin
      @(posedge clk);
      #1;
      seen = done;
      if (busy !== 1'b1)
        note_mismatch("busy", busy, 1);
      #1;
      go = (cyc == 10);  // Second go in the middle of the run
      if (cyc == 10)
        cfg = c2;
      cyc++;
    end
    go = 1'b0;
    if (!seen)
      note_failure("timed out waiting for done");
    // Nothing may follow the run
    for (int i = 0; i < 20; i++)
    begin
      @(posedge clk);
      #1;
      if (busy !== 1'b0)
        note_mismatch("busy", busy, 0);
      if (rd_req.req !== 1'b0)
        note_mismatch("rd_req.req", rd_req.req, 0);
    end
    #2;
    if (done_cnt != 1)
      note_failure($sformatf("done pulsed %0d times instead of once", done_cnt));
    check_output(c);
  endtask

  task automatic test_slow_writes();
    cnn_cfg_t c;
    mem0.wr_lat_fixed = 5;
    randomize_inputs(8'h3f);
    c = make_cfg('h6000, 'h6100, 'h6200, 'h6300);
    run_conv(c);
    check_output(c);
    mem0.wr_lat_fixed = 0;
  endtask

  task automatic test_back_to_back();
    cnn_cfg_t c;
    randomize_inputs(8'hff);
    c = make_cfg('h7000, 'h7100, 'h7200, 'h7300);
    run_conv(c);
    check_output(c);
    randomize_inputs(8'h3f);  // New kernel and bias must be fetched again
    c = make_cfg('h8000, 'h8100, 'h8200, 'h8300);
    run_conv(c);
    check_output(c);
  endtask

  initial
  begin
    seed        = 94604;
    clk         = 1'b0;
    rst_n       = 1'b0;
    go          = 1'b0;
    cfg         = '0;
    run_cfg     = '0;
    mismatches  = 0;
    failures    = 0;
    done_cnt    = 0;
    wr_req_prev = 1'b0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_idle();
    test_basic_conv();
    test_clamp();
    test_busy_done();
    test_slow_writes();
    test_back_to_back();

    repeat (2) @(posedge clk);
    #2;
    $display("Finished with %0d mismatches and %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
hw/cnn_mem_pkg.sv
hw/cnn_arith_pkg.sv
hw/cnn_cfg_regs.sv
hw/cnn_ctrl.sv
hw/cnn_mac.sv
hw/cnn_out_pack.sv
hw/cnn_top.sv
tb/cnn_mem_model.sv
tb/cnn_tb.sv

// ==== Bender.yml ====
package:
  name: cnn_conv

sources:
  - files:
      - hw/cnn_mem_pkg.sv
      - hw/cnn_arith_pkg.sv
      - hw/cnn_cfg_regs.sv
      - hw/cnn_ctrl.sv
      - hw/cnn_mac.sv
      - hw/cnn_out_pack.sv
      - hw/cnn_top.sv
  - target: test
    files:
      - tb/cnn_mem_model.sv
      - tb/cnn_tb.sv
